/* branch_unit.f */
verilog/branch_types_pkg.sv
verilog/bus_map_pkg.sv
verilog/thread_counter.sv
verilog/table_write_port.sv
verilog/branch_check.sv
verilog/branch_merge.sv
verilog/branch_unit_top.sv
testbench/tb_clock_gen.sv
testbench/branch_unit_checker.sv
testbench/branch_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the branch_unit testbench with Verilator, runs it and checks the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module branch_unit_tb -Mdir "$build_dir" -f branch_unit.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

"./$build_dir/Vbranch_unit_tb" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$log_file"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation passed"
exit 0

/* testbench/branch_unit_checker.sv */
// concurrent checks bound into branch_unit_top
// the destination check only applies once every table entry holds a nonzero destination

`timescale 1ns/1ps

module branch_unit_checker
    import branch_types_pkg::*;
    import bus_map_pkg::*;
#(
    parameter int THREAD_COUNT = 4,
    parameter int BRANCH_COUNT = 2
)
(
    input logic                    clock,
    input logic                    rst_n,
    input logic                    wb_cyc,
    input logic                    wb_stb,
    input logic                    wb_ack,
    input logic                    jump,
    input logic                    cancel,
    input pc_t                     branch_destination,
    input logic [BRANCH_COUNT-1:0] table_wren,
    input table_field_e            table_field,
    input thread_t                 table_thread,
    input wb_dat_t                 table_data
);

    // one bit per unit and thread, set while that entry's destination is nonzero
    logic [BRANCH_COUNT*THREAD_COUNT-1:0] destination_set;
    logic                                 zero_destination;
    int                                   failure_count = 0;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            destination_set <= '0;
        end else if (table_field == field_destination) begin
            for (int i = 0; i < BRANCH_COUNT; i++) begin
                if (table_wren[i]) begin
                    destination_set[i*THREAD_COUNT + int'(table_thread)] <=
                        (table_data[PC_WIDTH-1:0] != '0);
                end
            end
        end
    end

    assign zero_destination = !(&destination_set);

    // ----------------------------------------
    // bus handshake
    // ----------------------------------------

    ack_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            failure_count++;
            $error("wb_ack stayed high for two cycles");
        end

    ack_after_request: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else begin
            failure_count++;
            $error("wb_ack rose without a cyc and stb request");
        end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    reset_outputs_low: assert property (@(posedge clock)
        !rst_n |-> (!jump && !cancel && !wb_ack && (branch_destination == '0)))
        else begin
            failure_count++;
            $error("jump, cancel, branch_destination or wb_ack active during reset");
        end

    // the tables seen by a result were those present three sampling edges earlier
    jump_has_destination: assert property (@(posedge clock) disable iff (!rst_n)
        jump |-> ((branch_destination != '0) || $past(zero_destination, 3)))
        else begin
            failure_count++;
            $error("jump raised with a zero destination");
        end

endmodule

bind branch_unit_top branch_unit_checker #(
    .THREAD_COUNT (THREAD_COUNT),
    .BRANCH_COUNT (BRANCH_COUNT)
) i_branch_unit_checker (
    .clock              (clock),
    .rst_n              (rst_n),
    .wb_cyc             (wb_cyc),
    .wb_stb             (wb_stb),
    .wb_ack             (wb_ack),
    .jump               (jump),
    .cancel             (cancel),
    .branch_destination (branch_destination),
    .table_wren         (table_wren),
    .table_field        (table_field),
    .table_thread       (table_thread),
    .table_data         (table_data)
);

/* testbench/branch_unit_tb.sv */
// random table loads and instruction stream for branch_unit_top, seed 15
// inputs change on rising edges, the model and the checks run on falling edges
// assumes the default four threads and two branch units

`timescale 1ns/1ps

module branch_unit_tb
    import branch_types_pkg::*;
    import bus_map_pkg::*;
();

    localparam int THREAD_COUNT = 4;
    localparam int BRANCH_COUNT = 2;
    // stream and drain cycles, 52 bus accesses of about 3 cycles each, then reset
    localparam int TEST_CYCLES  = 1370 + 4 + 52 * 3 + 5;
    localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

    typedef logic [PC_WIDTH+1:0] result_t;

    logic    clock;
    logic    rst_n;
    logic    wb_cyc;
    logic    wb_stb;
    logic    wb_we;
    wb_adr_t wb_adr;
    wb_dat_t wb_dat_w;
    logic    wb_ack;
    wb_dat_t wb_dat_r;
    pc_t     pc;
    flags_t  flags;
    logic    jump;
    pc_t     branch_destination;
    logic    cancel;

    // table mirror built from the bus writes that the model sees acknowledged
    pc_t   model_origin      [BRANCH_COUNT][THREAD_COUNT];
    pc_t   model_destination [BRANCH_COUNT][THREAD_COUNT];
    cond_t model_condition   [BRANCH_COUNT][THREAD_COUNT];
    logic  model_prediction  [BRANCH_COUNT][THREAD_COUNT];
    logic  model_enable      [BRANCH_COUNT][THREAD_COUNT];

    result_t expected_q[$];
    int      sample_count;
    int      cycle_count = 0;
    int      check_count = 0;
    int      error_count = 0;
    int      checks_at_start = 0;
    int      errors_at_start = 0;

    tb_clock_gen i_tb_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    branch_unit_top #(
        .THREAD_COUNT (THREAD_COUNT),
        .BRANCH_COUNT (BRANCH_COUNT)
    ) i_branch_unit_top (
        .clock              (clock),
        .rst_n              (rst_n),
        .wb_cyc             (wb_cyc),
        .wb_stb             (wb_stb),
        .wb_we              (wb_we),
        .wb_adr             (wb_adr),
        .wb_dat_w           (wb_dat_w),
        .wb_ack             (wb_ack),
        .wb_dat_r           (wb_dat_r),
        .pc                 (pc),
        .flags              (flags),
        .jump               (jump),
        .branch_destination (branch_destination),
        .cancel             (cancel)
    );

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // each falling edge stands for the next sampling edge, whose thread is the
    // number of sampling edges since reset, wrapped at THREAD_COUNT
    always @(negedge clock) begin : reference_model
        int      unit;
        thread_t t;
        logic    hit;
        logic    flag;
        logic    exp_jump;
        logic    exp_cancel;
        pc_t     exp_destination;
        result_t expected;

        if (!rst_n) begin
            expected_q.delete();
            sample_count = 0;
            for (int u = 0; u < BRANCH_COUNT; u++) begin
                for (int n = 0; n < THREAD_COUNT; n++) begin
                    model_origin[u][n]      = '0;
                    model_destination[u][n] = '0;
                    model_condition[u][n]   = '0;
                    model_prediction[u][n]  = 1'b0;
                    model_enable[u][n]      = 1'b0;
                end
            end
        end else begin
            // an ack now means the write landed on the edge just gone
            if (wb_ack && wb_we) begin
                unit = int'(wb_adr[ADR_UNIT_MSB:ADR_UNIT_LSB]);
                t    = wb_adr[ADR_THREAD_MSB:ADR_THREAD_LSB];
                if (unit < BRANCH_COUNT) begin
                    case (wb_adr[ADR_FIELD_MSB:ADR_FIELD_LSB])
                        field_origin:            model_origin[unit][t] = wb_dat_w[PC_WIDTH-1:0];
                        field_destination:       model_destination[unit][t] = wb_dat_w[PC_WIDTH-1:0];
                        field_condition:         model_condition[unit][t] = wb_dat_w[2:0];
                        field_prediction:        model_prediction[unit][t] = wb_dat_w[0];
                        field_prediction_enable: model_enable[unit][t] = wb_dat_w[0];
                        default: ;
                    endcase
                end
            end

            // the oldest entry was sampled two edges before the last one
            if (expected_q.size() == 3) begin
                expected = expected_q.pop_front();
                check_count++;
                if ({jump, cancel, branch_destination} !== expected) begin
                    error_count++;
                    $display("[ERROR] %0t: got jump %b cancel %b destination %0d,",
                             $time, jump, cancel, branch_destination);
                    $display("[ERROR] %0t: expected jump %b cancel %b destination %0d",
                             $time, expected[PC_WIDTH+1], expected[PC_WIDTH],
                             expected[PC_WIDTH-1:0]);
                end
            end

            t               = thread_t'(sample_count % THREAD_COUNT);
            exp_jump        = 1'b0;
            exp_cancel      = 1'b0;
            exp_destination = '0;
            for (int u = 0; u < BRANCH_COUNT; u++) begin
                hit  = (pc == model_origin[u][t]);
                flag = flags[model_condition[u][t]];
                if (hit && flag) begin
                    exp_jump        = 1'b1;
                    exp_destination = exp_destination | model_destination[u][t];
                end
                if (hit && model_enable[u][t] && (model_prediction[u][t] != flag)) begin
                    exp_cancel = 1'b1;
                end
            end
            expected_q.push_back({exp_jump, exp_cancel, exp_destination});
            sample_count++;
        end
    end

    // ----------------------------------------
    // bus and stream drivers
    // ----------------------------------------

    // a classic cycle whose ack must follow the edge that samples the request
    task automatic bus_access(input logic write, input wb_adr_t adr, input wb_dat_t data,
                              output wb_dat_t read_data);
        int cycles;

        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= write;
        wb_adr   <= adr;
        wb_dat_w <= data;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while ((wb_ack !== 1'b1) && cycles < 8);
        check_count++;
        if (wb_ack !== 1'b1) begin
            error_count++;
            $display("no acknowledge from the table port within %0d cycles", cycles);
        end else if (cycles != 2) begin
            error_count++;
            $display("[ERROR] %0t: ack after %0d cycles, expected 1", $time, cycles - 1);
        end
        read_data = wb_dat_r;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_field(input int unit, input thread_t t, input table_field_e field,
                               input wb_dat_t data);
        wb_dat_t ignored;

        bus_access(1'b1, {3'(unit), t, field}, data, ignored);
    endtask

    // misses never use pc zero, so empty tables cannot match
    function automatic pc_t pick_pc(input int hit_percent);
        if (int'($urandom % 100) < hit_percent) begin
            return model_origin[$urandom % BRANCH_COUNT][$urandom % THREAD_COUNT];
        end
        return pc_t'(1 + $urandom % 1023);
    endfunction

    task automatic run_stream(input int cycles, input int hit_percent);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            pc    <= pick_pc(hit_percent);
            flags <= flags_t'($urandom);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, check_count - checks_at_start,
                 error_count - errors_at_start);
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    // ----------------------------------------
    // run limit
    // ----------------------------------------

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // tests
    // ----------------------------------------

    initial begin : stimulus
        wb_dat_t read_data;
        wb_dat_t data;
        thread_t rewrite_thread;

        void'($urandom(15));
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        pc       = '0;
        flags    = '0;
        @(posedge rst_n);

        run_stream(40, 0);
        report_test("reset state with empty tables");

        // odd destinations keep every loaded destination nonzero
        for (int u = 0; u < BRANCH_COUNT; u++) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                write_field(u, thread_t'(t), field_origin, wb_dat_t'($urandom));
                write_field(u, thread_t'(t), field_destination, wb_dat_t'($urandom) | 16'h1);
                write_field(u, thread_t'(t), field_condition, wb_dat_t'($urandom));
            end
        end
        run_stream(400, 75);
        report_test("jump and destination");

        for (int u = 0; u < BRANCH_COUNT; u++) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                write_field(u, thread_t'(t), field_prediction, wb_dat_t'($urandom));
                write_field(u, thread_t'(t), field_prediction_enable, wb_dat_t'($urandom));
            end
        end
        run_stream(400, 75);
        report_test("prediction and cancel");

        bus_access(1'b0, {3'd0, thread_t'($urandom), field_origin}, '0, read_data);
        check_count++;
        if (read_data !== '0) begin
            error_count++;
            $display("[ERROR] %0t: read returned %h, expected 0", $time, read_data);
        end
        bus_access(1'b1, {3'(BRANCH_COUNT + $urandom % (8 - BRANCH_COUNT)),
                          thread_t'($urandom), field_origin},
                   wb_dat_t'($urandom), read_data);
        run_stream(200, 75);
        report_test("read and write to a missing unit");

        // rewrites land between stream cycles, so some inputs see old entries
        run_stream(100, 75);
        rewrite_thread = thread_t'($urandom);
        for (int u = 0; u < BRANCH_COUNT; u++) begin
            for (int f = 0; f < 5; f++) begin
                data = wb_dat_t'($urandom) | ((f == 1) ? 16'h1 : 16'h0);
                write_field(u, rewrite_thread, table_field_e'(f), data);
                run_stream(3, 75);
            end
        end
        run_stream(200, 75);
        // the last input needs the sampling edge and two more before its result is checked
        repeat (4) @(posedge clock);
        report_test("mid-stream table rewrite");

        error_count += i_branch_unit_top.i_branch_unit_checker.failure_count;
        $display("all tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
// 40 ns clock with rst_n held low for the first four rising edges
// rst_n is released a quarter period after an edge, clear of both clock edges

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
)
(
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #(HALF_PERIOD / 2);
        rst_n = 1'b1;
    end

endmodule

/* verilog/branch_check.sv */
// one branch unit holding origin, destination, condition and prediction
// entries for every thread; all outputs are zero when the unit misses
// a table write on edge k is not seen by the input sampled on edge k

`timescale 1ns/1ps

module branch_check
    import branch_types_pkg::*;
    import bus_map_pkg::*;
#(
    parameter int THREAD_COUNT = 4
)
(
    input  logic         clock,
    input  logic         rst_n,
    input  thread_t      thread,
    input  pc_t          pc,
    input  flags_t       flags,
    input  logic         table_wren,
    input  table_field_e table_field,
    input  thread_t      table_thread,
    input  wb_dat_t      table_data,
    output logic         unit_jump,
    output pc_t          unit_destination,
    output logic         unit_cancel
);

    pc_t   origin_table            [THREAD_COUNT];
    pc_t   destination_table       [THREAD_COUNT];
    cond_t condition_table         [THREAD_COUNT];
    logic  prediction_table        [THREAD_COUNT];
    logic  prediction_enable_table [THREAD_COUNT];

    pc_t    s1_pc;
    flags_t s1_flags;
    pc_t    s1_origin;
    pc_t    s1_destination;
    cond_t  s1_condition;
    logic   s1_prediction;
    logic   s1_prediction_enable;

    logic hit;
    logic flag;

    // ----------------------------------------
    // per-thread tables
    // ----------------------------------------

    // only the low bits of the bus word that fit the field are kept
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < THREAD_COUNT; t++) begin
                origin_table[t]            <= '0;
                destination_table[t]       <= '0;
                condition_table[t]         <= '0;
                prediction_table[t]        <= 1'b0;
                prediction_enable_table[t] <= 1'b0;
            end
        end else if (table_wren) begin
            case (table_field)
                field_origin:            origin_table[table_thread]      <= table_data[PC_WIDTH-1:0];
                field_destination:       destination_table[table_thread] <= table_data[PC_WIDTH-1:0];
                field_condition:         condition_table[table_thread]   <= table_data[$bits(cond_t)-1:0];
                field_prediction:        prediction_table[table_thread]  <= table_data[0];
                field_prediction_enable: prediction_enable_table[table_thread] <= table_data[0];
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // stage one, capture input and entries
    // ----------------------------------------

    always_ff @(posedge clock) begin
        s1_pc                <= pc;
        s1_flags             <= flags;
        s1_origin            <= origin_table[thread];
        s1_destination       <= destination_table[thread];
        s1_condition         <= condition_table[thread];
        s1_prediction        <= prediction_table[thread];
        s1_prediction_enable <= prediction_enable_table[thread];
    end

    // ----------------------------------------
    // stage two, origin and condition check
    // ----------------------------------------

    assign hit  = (s1_pc == s1_origin);
    assign flag = s1_flags[s1_condition];

    // a cancel is raised on a hit whose real outcome differs from the
    // enabled prediction, whether or not the branch is taken
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            unit_jump        <= 1'b0;
            unit_destination <= '0;
            unit_cancel      <= 1'b0;
        end else begin
            unit_jump        <= hit && flag;
            unit_destination <= (hit && flag) ? s1_destination : '0;
            unit_cancel      <= hit && s1_prediction_enable && (s1_prediction != flag);
        end
    end

endmodule

/* verilog/branch_merge.sv */
// OR-reduction of all branch units into the registered result
// relies on every missing unit driving zero on all of its outputs

`timescale 1ns/1ps

module branch_merge
    import branch_types_pkg::*;
#(
    parameter int BRANCH_COUNT = 2
)
(
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic [BRANCH_COUNT-1:0]          unit_jump,
    input  logic [BRANCH_COUNT*PC_WIDTH-1:0] unit_destination,
    input  logic [BRANCH_COUNT-1:0]          unit_cancel,
    output logic                             jump,
    output pc_t                              branch_destination,
    output logic                             cancel
);

    pc_t destination_any;

    // two units hitting at once would mix destinations, the tables must
    // give each thread at most one origin that can match
    always_comb begin
        destination_any = '0;
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            destination_any = destination_any | unit_destination[i*PC_WIDTH +: PC_WIDTH];
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            jump               <= 1'b0;
            branch_destination <= '0;
            cancel             <= 1'b0;
        end else begin
            jump               <= |unit_jump;
            branch_destination <= destination_any;
            cancel             <= |unit_cancel;
        end
    end

endmodule

/* verilog/branch_types_pkg.sv */
// datapath types shared by the branch units and the testbench
// thread_t is sized for four threads, so widen it before raising THREAD_COUNT
// table field codes match the low three bits of a table port address

package branch_types_pkg;

    // ----------------------------------------
    // datapath widths
    // ----------------------------------------

    // program counter of the processor's instruction memory
    typedef logic [9:0] pc_t;

    // result flags left behind by a thread's previous instruction
    typedef logic [7:0] flags_t;

    // index into flags_t naming the flag that a branch tests
    typedef logic [2:0] cond_t;

    // thread number, enough for the default of four threads
    typedef logic [1:0] thread_t;

    localparam int PC_WIDTH = $bits(pc_t);

    // ----------------------------------------
    // per-thread table fields
    // ----------------------------------------

    // codes 5 to 7 are unused and writes to them are dropped
    typedef enum logic [2:0] {
        field_origin            = 3'd0,
        field_destination       = 3'd1,
        field_condition         = 3'd2,
        field_prediction        = 3'd3,
        field_prediction_enable = 3'd4
    } table_field_e;

endpackage

/* verilog/branch_unit_top.sv */
// branch resolution block of the barrel processor
// results for an input sampled on edge k appear after edge k+2
// BRANCH_COUNT may be at most 8, THREAD_COUNT at most 4

`timescale 1ns/1ps

module branch_unit_top
    import branch_types_pkg::*;
    import bus_map_pkg::*;
#(
    parameter int THREAD_COUNT = 4,
    parameter int BRANCH_COUNT = 2
)
(
    input  logic    clock,
    input  logic    rst_n,
    input  logic    wb_cyc,
    input  logic    wb_stb,
    input  logic    wb_we,
    input  wb_adr_t wb_adr,
    input  wb_dat_t wb_dat_w,
    output logic    wb_ack,
    output wb_dat_t wb_dat_r,
    input  pc_t     pc,
    input  flags_t  flags,
    output logic    jump,
    output pc_t     branch_destination,
    output logic    cancel
);

    logic [BRANCH_COUNT-1:0]          table_wren;
    table_field_e                     table_field;
    thread_t                          table_thread;
    wb_dat_t                          table_data;
    thread_t                          thread;
    logic [BRANCH_COUNT-1:0]          unit_jump;
    logic [BRANCH_COUNT*PC_WIDTH-1:0] unit_destination;
    logic [BRANCH_COUNT-1:0]          unit_cancel;

    // ----------------------------------------
    // host write path and thread sequencing
    // ----------------------------------------

    table_write_port #(
        .THREAD_COUNT (THREAD_COUNT),
        .BRANCH_COUNT (BRANCH_COUNT)
    ) i_table_write_port (
        .clock        (clock),
        .rst_n        (rst_n),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .wb_dat_r     (wb_dat_r),
        .table_wren   (table_wren),
        .table_field  (table_field),
        .table_thread (table_thread),
        .table_data   (table_data)
    );

    thread_counter #(
        .THREAD_COUNT (THREAD_COUNT)
    ) i_thread_counter (
        .clock  (clock),
        .rst_n  (rst_n),
        .thread (thread)
    );

    // ----------------------------------------
    // branch units and merge
    // ----------------------------------------

    for (genvar i = 0; i < BRANCH_COUNT; i++) begin : g_unit
        branch_check #(
            .THREAD_COUNT (THREAD_COUNT)
        ) i_branch_check (
            .clock            (clock),
            .rst_n            (rst_n),
            .thread           (thread),
            .pc               (pc),
            .flags            (flags),
            .table_wren       (table_wren[i]),
            .table_field      (table_field),
            .table_thread     (table_thread),
            .table_data       (table_data),
            .unit_jump        (unit_jump[i]),
            .unit_destination (unit_destination[i*PC_WIDTH +: PC_WIDTH]),
            .unit_cancel      (unit_cancel[i])
        );
    end

    branch_merge #(
        .BRANCH_COUNT (BRANCH_COUNT)
    ) i_branch_merge (
        .clock              (clock),
        .rst_n              (rst_n),
        .unit_jump          (unit_jump),
        .unit_destination   (unit_destination),
        .unit_cancel        (unit_cancel),
        .jump               (jump),
        .branch_destination (branch_destination),
        .cancel             (cancel)
    );

endmodule

/* verilog/bus_map_pkg.sv */
// Wishbone widths and the address map of the branch table port
// only writes reach the tables and reads always return zero
// data bits above a field's width are ignored by the units

package bus_map_pkg;

    typedef logic [7:0]  wb_adr_t;
    typedef logic [15:0] wb_dat_t;

    // ----------------------------------------
    // address layout
    // ----------------------------------------

    // bits 2 to 0 select the table field
    localparam int ADR_FIELD_LSB  = 0;
    localparam int ADR_FIELD_MSB  = 2;

    // bits 4 to 3 select the thread whose entry is written
    localparam int ADR_THREAD_LSB = 3;
    localparam int ADR_THREAD_MSB = 4;

    // bits 7 to 5 select the branch unit, so at most eight units exist
    localparam int ADR_UNIT_LSB   = 5;
    localparam int ADR_UNIT_MSB   = 7;

    // slave FSM, which only waits for a request or returns the ack
    typedef enum logic {
        bus_idle = 1'b0,
        bus_ack  = 1'b1
    } bus_state_e;

endpackage

/* verilog/table_write_port.sv */
// Wishbone classic slave for the branch tables, one ack cycle per access
// reads are acknowledged and return zero, since there is no table read-back
// writes to a missing unit, thread or an unused field code are acked and dropped

`timescale 1ns/1ps

module table_write_port
    import branch_types_pkg::*;
    import bus_map_pkg::*;
#(
    parameter int THREAD_COUNT = 4,
    parameter int BRANCH_COUNT = 2
)
(
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  wb_adr_t                 wb_adr,
    input  wb_dat_t                 wb_dat_w,
    output logic                    wb_ack,
    output wb_dat_t                 wb_dat_r,
    output logic [BRANCH_COUNT-1:0] table_wren,
    output table_field_e            table_field,
    output thread_t                 table_thread,
    output wb_dat_t                 table_data
);

    bus_state_e state;
    logic       request;
    logic       write_ok;
    logic [ADR_UNIT_MSB-ADR_UNIT_LSB:0] unit_index;

    // a new request is only seen while ack is low
    assign request = (state == bus_idle) && wb_cyc && wb_stb;

    // ----------------------------------------
    // ack FSM
    // ----------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= bus_idle;
        end else if (state == bus_idle) begin
            if (request) begin
                state <= bus_ack;
            end
        end else begin
            // ack lasts one cycle, the host drops its request on seeing it
            state <= bus_idle;
        end
    end

    assign wb_ack   = (state == bus_ack);
    assign wb_dat_r = '0;

    // ----------------------------------------
    // write decode
    // ----------------------------------------

    assign unit_index   = wb_adr[ADR_UNIT_MSB:ADR_UNIT_LSB];
    assign table_field  = table_field_e'(wb_adr[ADR_FIELD_MSB:ADR_FIELD_LSB]);
    assign table_thread = thread_t'(wb_adr[ADR_THREAD_MSB:ADR_THREAD_LSB]);
    assign table_data   = wb_dat_w;

    assign write_ok = request && wb_we
                   && (int'(unit_index) < BRANCH_COUNT)
                   && (int'(table_thread) < THREAD_COUNT)
                   && (table_field inside {field_origin, field_destination,
                                           field_condition, field_prediction,
                                           field_prediction_enable});

    // the strobe is high in the request cycle, so the table takes the data
    // on the same edge that raises ack
    always_comb begin
        for (int i = 0; i < BRANCH_COUNT; i++) begin
            table_wren[i] = write_ok && (int'(unit_index) == i);
        end
    end

endmodule

/* verilog/thread_counter.sv */
// round robin thread number seen by every branch unit
// the processor issues one thread per clock, starting at thread 0 after reset

`timescale 1ns/1ps

module thread_counter
    import branch_types_pkg::*;
#(
    parameter int THREAD_COUNT = 4
)
(
    input  logic    clock,
    input  logic    rst_n,
    output thread_t thread
);

    // the value held before an edge is the thread whose pc and flags
    // are sampled on that edge
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            thread <= '0;
        end else if (thread == thread_t'(THREAD_COUNT - 1)) begin
            // wrap so that counts below the thread_t range still cycle
            thread <= '0;
        end else begin
            thread <= thread + 1'b1;
        end
    end

endmodule
